//--- project.f
+incdir+source
+incdir+tests
source/angle_pkg.sv
source/audio_pkg.sv
source/phase_accumulator.sv
source/cordic_sin.sv
source/voice_control.sv
source/sine_voice_top.sv
tests/tb_sine_voice.sv

//--- run_sim.sh
#!/bin/sh
# build the sine voice testbench with verilator and run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sine_voice -f project.f > build.log 2>&1 \
    && ./obj_dir/Vtb_sine_voice > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- source/angle_pkg.sv
`include "synth_params.svh"

package angle_pkg;

    // signed fixed point, 2^15 per radian
    // also used for the cordic x/y coordinates
    typedef logic signed [`ANGLE_W-1:0] angle_t;

    // cordic sequencer states
    typedef enum logic [1:0] {
        S0      = 2'h0,    // idle after reset
        INIT    = 2'h1,    // load x/y/angle seeds
        COMPUTE = 2'h2,    // shift-and-add iterations
        DONE    = 2'h3     // result valid, waits for next update
    } cordic_state_t;

    // voice configuration from outside
    typedef struct packed {
        logic   enable;    // run the sample timer
        angle_t step;      // phase increment per sample, below pi
    } tone_config_t;

endpackage

//--- source/audio_pkg.sv
`include "synth_params.svh"

package audio_pkg;

    // signed pcm sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // sample output towards the consumer
    typedef struct packed {
        logic    strobe;   // one cycle per new sample
        sample_t value;    // holds last sample between strobes
    } sample_out_t;

endpackage

//--- source/cordic_sin.sv
`timescale 1ns/1ps
`include "synth_params.svh"

module cordic_sin (
    input  logic               clk,
    input  logic               reset,
    input  logic               update,
    input  angle_pkg::angle_t  angle,
    output audio_pkg::sample_t result,
    output logic               ready
);

    // quadrant bounds, compared unsigned on the raw angle bits
    localparam logic [`ANGLE_W-1:0] Q1 = `PI2;
    localparam logic [`ANGLE_W-1:0] Q2 = 2 * `PI2;
    localparam logic [`ANGLE_W-1:0] Q3 = 3 * `PI2;
    localparam logic [`ANGLE_W-1:0] Q4 = 4 * `PI2;     // 2pi

    // input range is 0 .. 3pi, pull anything above 2pi back by one turn
    function automatic logic [`ANGLE_W-1:0] wrap_2pi(input logic [`ANGLE_W-1:0] a);
        return (a > Q4) ? a - Q4 : a;
    endfunction

    // 0..3 for the quadrant the angle lies in
    function automatic logic [1:0] quadrant(input logic [`ANGLE_W-1:0] a);
        logic [`ANGLE_W-1:0] m;
        m = wrap_2pi(a);
        if (m > Q3) begin
            return 2'd3;
        end else if (m > Q2) begin
            return 2'd2;
        end else if (m > Q1) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    // first-quadrant angle with |sin(a)| == sin(result)
    function automatic angle_pkg::angle_t angle_adj(input logic [`ANGLE_W-1:0] a);
        logic [`ANGLE_W-1:0] m;
        logic [`ANGLE_W-1:0] f;
        m = wrap_2pi(a);
        if (m > Q3) begin
            f = Q4 - m;                          // mirror about 2pi
        end else if (m > Q2) begin
            f = m - Q2;                          // shift down by pi
        end else if (m > Q1) begin
            f = Q2 - m;                          // mirror about pi
        end else begin
            f = m;
        end
        return angle_pkg::angle_t'(f);
    endfunction

    // atan(2^-i) in the angle scale
    function automatic angle_pkg::angle_t atan_entry(input logic [4:0] i);
        case (i)
            5'h00:   return 18'h06487;
            5'h01:   return 18'h03B58;
            5'h02:   return 18'h01F5B;
            5'h03:   return 18'h00FEA;
            5'h04:   return 18'h007FD;
            5'h05:   return 18'h003FF;
            5'h06:   return 18'h001FF;
            5'h07:   return 18'h000FF;
            5'h08:   return 18'h0007F;
            5'h09:   return 18'h0003F;
            5'h0A:   return 18'h0001F;
            5'h0B:   return 18'h0000F;
            5'h0C:   return 18'h00007;
            5'h0D:   return 18'h00003;
            5'h0E:   return 18'h00001;
            5'h0F:   return 18'h00000;           // below resolution from here on
            5'h10:   return 18'h00000;
            default: return 18'h00000;
        endcase
    endfunction

    angle_pkg::cordic_state_t state, state_next;
    logic [4:0]               ctr, ctr_next;              // iteration index

    angle_pkg::angle_t x, x_next;                         // cos track, scaled by 1/K
    angle_pkg::angle_t y, y_next;                         // sin track
    angle_pkg::angle_t cur_angle, cur_next;               // angle rotated so far
    angle_pkg::angle_t target;                            // folded input angle
    angle_pkg::angle_t y_half;                            // signed, halved y
    logic [1:0]        quad;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= angle_pkg::S0;
            ctr   <= '0;
        end else begin
            state <= state_next;
            ctr   <= ctr_next;
        end
    end

    // rotation datapath registers
    always_ff @(posedge clk) begin
        x         <= x_next;
        y         <= y_next;
        cur_angle <= cur_next;
    end

    always_comb begin
        target     = angle_adj(angle);                    // angle held stable by the accumulator
        quad       = quadrant(angle);
        state_next = state;
        ctr_next   = ctr;
        x_next     = x;
        y_next     = y;
        cur_next   = cur_angle;
        y_half     = '0;
        result     = '0;
        ready      = 1'b0;
        case (state)
            angle_pkg::S0: begin
                ctr_next = '0;
                if (update) begin
                    state_next = angle_pkg::INIT;
                end
            end
            angle_pkg::INIT: begin
                x_next     = `AG_CONST;                   // gain pre-compensated start vector
                y_next     = '0;
                cur_next   = '0;
                ctr_next   = '0;
                state_next = angle_pkg::COMPUTE;
            end
            angle_pkg::COMPUTE: begin
                if (target > cur_angle) begin             // rotate counter-clockwise
                    x_next   = x - (y >>> ctr);
                    y_next   = y + (x >>> ctr);
                    cur_next = cur_angle + atan_entry(ctr);
                end else begin                            // rotate clockwise
                    x_next   = x + (y >>> ctr);
                    y_next   = y - (x >>> ctr);
                    cur_next = cur_angle - atan_entry(ctr);
                end
                ctr_next = ctr + 5'd1;
                if (ctr >= 5'(`CORDIC_STEPS)) begin       // 17th iteration just ran
                    state_next = angle_pkg::DONE;
                end
            end
            angle_pkg::DONE: begin
                // lower half-plane for quadrants 2 and 3
                y_half = (quad < 2'd2) ? (y >>> 1) : ((-y) >>> 1);
                result = audio_pkg::sample_t'(y_half[`SAMPLE_W-1:0]);
                ready  = 1'b1;
                if (update) begin
                    state_next = angle_pkg::INIT;
                end
            end
            default: begin
                state_next = angle_pkg::S0;
            end
        endcase
    end

endmodule

//--- source/phase_accumulator.sv
`timescale 1ns/1ps
`include "synth_params.svh"

module phase_accumulator (
    input  logic              clk,
    input  logic              reset,
    input  logic              tick,
    input  angle_pkg::angle_t step,
    output angle_pkg::angle_t angle
);

    localparam logic [`ANGLE_W:0] TWO_PI = 4 * `PI2;  // same bound as the cordic fold

    logic [`ANGLE_W-1:0] phase;      // wrapped phase, 0 .. 2pi
    logic [`ANGLE_W:0]   sum;        // one spare bit, sum reaches just under 3pi
    logic [`ANGLE_W:0]   wrapped;    // next stored phase
    logic [`ANGLE_W-1:0] presented;  // angle handed to the cordic

    always_comb begin
        sum     = {1'b0, phase} + {1'b0, step};            // step is always positive
        wrapped = (sum > TWO_PI) ? sum - TWO_PI : sum;     // fold back into 0 .. 2pi

        // sums that still fit 18 bits go out unwrapped so the cordic
        // sees angles above 2pi; larger ones would alias, the wrapped
        // value lands in the same quadrant with the same sine
        if (sum[`ANGLE_W]) begin
            presented = wrapped[`ANGLE_W-1:0];
        end else begin
            presented = sum[`ANGLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            angle <= '0;
        end else if (tick) begin
            phase <= wrapped[`ANGLE_W-1:0];               // at most 2pi, fits
            angle <= angle_pkg::angle_t'(presented);      // stable until next tick
        end
    end

endmodule

//--- source/sine_voice_top.sv
`timescale 1ns/1ps

module sine_voice_top (
    input  logic                     clk,
    input  logic                     reset,
    input  angle_pkg::tone_config_t  cfg,
    output audio_pkg::sample_out_t   sample
);

    logic               tick;       // sample timer pulse
    logic               update;     // start cordic, one cycle after tick
    logic               ready;      // cordic result valid
    angle_pkg::angle_t  angle;      // phase for the current sample
    audio_pkg::sample_t result;     // raw cordic sine

    voice_control voice_control0 (
        .clk    (clk),
        .reset  (reset),
        .enable (cfg.enable),
        .ready  (ready),
        .result (result),
        .tick   (tick),
        .update (update),
        .sample (sample)
    );

    phase_accumulator phase_accumulator0 (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .step  (cfg.step),
        .angle (angle)
    );

    cordic_sin cordic_sin0 (
        .clk    (clk),
        .reset  (reset),
        .update (update),
        .angle  (angle),
        .result (result),
        .ready  (ready)
    );

endmodule

//--- source/synth_params.svh
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// fixed-point scale: 2^15 per radian

// datapath widths
`define ANGLE_W       18            // angles and cordic coordinates
`define SAMPLE_W      16            // audio sample

// angle constants
`define PI2           18'hC910      // pi/2
`define AG_CONST      18'h4DBA      // 1/K, about 0.6073

// cordic iteration count
`define CORDIC_STEPS  16            // last iteration index, 17 iterations

// sample rate divider
// one tick every SAMPLE_DIV clocks, must exceed the 21 cycle
// tick to strobe latency of the voice
`define SAMPLE_DIV    32

`endif

//--- source/voice_control.sv
`timescale 1ns/1ps
`include "synth_params.svh"

module voice_control (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   ready,
    input  audio_pkg::sample_t     result,
    output logic                   tick,
    output logic                   update,
    output audio_pkg::sample_out_t sample
);

    localparam int DIV_W = $clog2(`SAMPLE_DIV);           // counter holds 0 .. SAMPLE_DIV-1

    logic [DIV_W-1:0] div_cnt;                            // sample timer
    logic             ready_d;                            // ready one cycle late
    logic             ready_rise;                         // cordic just reached DONE

    // last cycle of each period, never while disabled
    assign tick       = enable && (div_cnt == DIV_W'(`SAMPLE_DIV - 1));
    assign ready_rise = ready && !ready_d;

    // sample timer
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (!enable) begin
            div_cnt <= '0;                                // restart a full period on enable
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // update trails tick so the accumulator has already loaded the angle
    always_ff @(posedge clk) begin
        if (reset) begin
            update  <= 1'b0;
            ready_d <= 1'b0;
        end else begin
            update  <= tick;
            ready_d <= ready;
        end
    end

    // output sample register, value holds between strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else begin
            sample.strobe <= ready_rise;                  // one cycle wide
            if (ready_rise) begin
                sample.value <= result;                   // result valid while ready
            end
        end
    end

endmodule

//--- tests/cordic_model.svh
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

`include "synth_params.svh"

// next stored phase after one tick
function automatic int model_wrap(input int phase, input int step);
    int turn;
    int sum;
    turn = 4 * `PI2;                                   // 2pi
    sum  = phase + step;
    return (sum > turn) ? sum - turn : sum;            // back into 0 .. 2pi
endfunction

// angle handed to the cordic on the same tick
function automatic int model_angle(input int phase, input int step);
    int sum;
    sum = phase + step;
    if (sum >= (1 << `ANGLE_W)) begin
        return sum - 4 * `PI2;                         // too wide for the port, goes out wrapped
    end
    return sum;                                        // may lie above 2pi
endfunction

// atan(2^-i), 2^15 per radian
function automatic logic signed [`ANGLE_W-1:0] model_atan(input int i);
    case (i)
        0:       return 18'h06487;
        1:       return 18'h03B58;
        2:       return 18'h01F5B;
        3:       return 18'h00FEA;
        4:       return 18'h007FD;
        5:       return 18'h003FF;
        6:       return 18'h001FF;
        7:       return 18'h000FF;
        8:       return 18'h0007F;
        9:       return 18'h0003F;
        10:      return 18'h0001F;
        11:      return 18'h0000F;
        12:      return 18'h00007;
        13:      return 18'h00003;
        14:      return 18'h00001;
        default: return 18'h00000;                     // below resolution
    endcase
endfunction

// sine of an angle in 0 .. 3pi, as the 16-bit sample
function automatic logic [`SAMPLE_W-1:0] model_sin(input int a);
    int turn;
    int m;
    int f;
    int i;
    bit lower;                                         // quadrants 2 and 3
    logic signed [`ANGLE_W-1:0] x;
    logic signed [`ANGLE_W-1:0] y;
    logic signed [`ANGLE_W-1:0] z;                     // angle rotated so far
    logic signed [`ANGLE_W-1:0] target;
    logic signed [`ANGLE_W-1:0] dx;
    logic signed [`ANGLE_W-1:0] dy;
    logic signed [`ANGLE_W-1:0] yh;
    turn  = 4 * `PI2;
    m     = (a > turn) ? a - turn : a;
    lower = 1'b0;
    if (m > 3 * `PI2) begin
        f     = turn - m;                              // mirror about 2pi
        lower = 1'b1;
    end else if (m > 2 * `PI2) begin
        f     = m - 2 * `PI2;                          // minus pi
        lower = 1'b1;
    end else if (m > `PI2) begin
        f = 2 * `PI2 - m;                              // mirror about pi
    end else begin
        f = m;
    end
    target = f[`ANGLE_W-1:0];
    x      = `AG_CONST;                                // start vector carries 1/K
    y      = '0;
    z      = '0;
    for (i = 0; i <= `CORDIC_STEPS; i++) begin
        dx = y >>> i;
        dy = x >>> i;
        if (target > z) begin
            x = x - dx;
            y = y + dy;
            z = z + model_atan(i);
        end else begin
            x = x + dx;
            y = y - dy;
            z = z - model_atan(i);
        end
    end
    if (lower) begin
        yh = -y;
        yh = yh >>> 1;
    end else begin
        yh = y >>> 1;
    end
    return yh[`SAMPLE_W-1:0];
endfunction

`endif

//--- tests/tb_sine_voice.sv
`timescale 1ns/1ps
`include "synth_params.svh"

module tb_sine_voice;

    localparam int CLK_PERIOD   = 100;                             // ns
    localparam int RESET_CYCLES = 10;
    localparam int TICK_LATENCY = 21;                              // tick to strobe
    localparam int FIRST_GAP    = `SAMPLE_DIV - 1 + TICK_LATENCY;  // enable edge to first strobe
    localparam int HALF_TURN    = 2 * `PI2;                        // steps stay below pi

    // planned work, sizes the watchdog
    localparam int N_FIXED   = 40;
    localparam int N_RANDOM  = 300;
    localparam int N_EXTREME = 4 * 20;
    localparam int N_SPACING = 16;
    localparam int N_TOGGLE  = 3 * 8;
    localparam int IDLE_MAX  = 200 + 5 + 3 * 120;                  // disabled cycles
    localparam int SAMPLES   = N_FIXED + N_RANDOM + N_EXTREME + N_SPACING + N_TOGGLE;
    localparam int LIMIT_NS  = (2 * (SAMPLES * `SAMPLE_DIV + IDLE_MAX) + RESET_CYCLES)
                               * CLK_PERIOD;

    logic                    clk;
    logic                    reset;
    angle_pkg::tone_config_t cfg;
    audio_pkg::sample_out_t  sample;

    int    seed;
    int    cycle = 0;                      // rising edges so far
    int    next_strobe;                    // cycle the next strobe is due
    int    model_phase;                    // wrapped phase of the model
    int    cur_step;                       // step currently driven
    int    n_pass;
    int    n_fail;
    int    test_errors;
    int    test_num;
    string test_name;
    logic [`SAMPLE_W-1:0] last_value;      // model sample the output should hold

    `include "cordic_model.svh"

    sine_voice_top dut0 (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg),
        .sample (sample)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle = cycle + 1;

    initial begin
        #(LIMIT_NS);
        $display("timeout: the simulation did not finish within %0d ns", LIMIT_NS);
        $display("Something failed");
        $finish;
    end

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic int random_step();
        int s;
        s = random_below(HALF_TURN);
        if (s == 0) begin
            s = 1;                         // zero step would freeze the tone
        end
        return s;
    endfunction

    task automatic count_check(input bit ok);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_num++;
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0d %s: passed", test_num, test_name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, test_name, test_errors);
        end
    endtask

    // new config 1 ns after the edge
    task automatic drive_cfg(input logic en, input int step);
        @(posedge clk);
        #1;
        if (en && !cfg.enable) begin
            next_strobe = cycle + FIRST_GAP;  // timer restarts from zero
        end
        cfg.enable = en;
        cfg.step   = angle_pkg::angle_t'(step);
        cur_step   = step;
    endtask

    // wait for one strobe, check its timing and value
    task automatic next_sample();
        int waited;
        int angle;
        logic [`SAMPLE_W-1:0] expected;
        @(negedge clk);
        waited = 1;
        while (!sample.strobe && waited < FIRST_GAP + `SAMPLE_DIV) begin
            @(negedge clk);
            waited++;
        end
        if (!sample.strobe) begin
            $display("no sample strobe within %0d cycles at %0t", waited, $time);
            count_check(1'b0);
            return;
        end
        if (cycle != next_strobe) begin
            $display("sample strobe came at cycle %0d, it was due at cycle %0d",
                     cycle, next_strobe);
            count_check(1'b0);
        end else begin
            count_check(1'b1);
        end
        next_strobe = cycle + `SAMPLE_DIV;
        angle       = model_angle(model_phase, cur_step);   // step is latched at the tick
        model_phase = model_wrap(model_phase, cur_step);
        expected    = model_sin(angle);
        last_value  = expected;
        if (sample.value !== expected) begin
            $display("Error: sample.value expected %h got %h (angle %h)",
                     expected, sample.value, angle);
            count_check(1'b0);
        end else begin
            count_check(1'b1);
        end
    endtask

    // voice disabled, output must stay frozen
    task automatic idle_check(input int n, input logic [`SAMPLE_W-1:0] held);
        int errs;
        errs = 0;
        repeat (n) begin
            @(negedge clk);
            if (sample.strobe) begin
                $display("sample strobe rose while the voice was disabled at %0t", $time);
                errs++;
            end
            if (sample.value !== held) begin
                $display("Error: sample.value expected %h got %h while disabled",
                         held, sample.value);
                errs++;
            end
        end
        count_check(errs == 0);
    endtask

    initial begin
        int ext_steps [4];
        int i;
        int k;
        seed        = 32'h1931;
        reset       = 1'b1;
        cfg         = '0;
        cur_step    = 0;
        model_phase = 0;
        next_strobe = 0;
        n_pass      = 0;
        n_fail      = 0;
        test_num    = 0;
        last_value  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("idle after reset");
        idle_check(200, '0);
        finish_test();

        start_test("fixed step");
        drive_cfg(1'b1, `PI2 / 8);
        repeat (N_FIXED) next_sample();
        finish_test();

        start_test("random steps");
        for (i = 0; i < N_RANDOM; i++) begin
            if (i % 8 == 0) begin
                drive_cfg(1'b1, random_step());  // lands before the next tick
            end
            next_sample();
        end
        finish_test();

        start_test("extreme steps");
        ext_steps[0] = HALF_TURN - 1;
        ext_steps[1] = 1;
        ext_steps[2] = HALF_TURN - 2;
        ext_steps[3] = `PI2;               // walks across the quadrant bounds
        for (i = 0; i < 4; i++) begin
            drive_cfg(1'b1, ext_steps[i]);
            repeat (N_EXTREME / 4) next_sample();
        end
        finish_test();

        start_test("strobe spacing");
        drive_cfg(1'b0, cur_step);
        idle_check(5, last_value);
        drive_cfg(1'b1, random_step());
        repeat (N_SPACING) next_sample();
        finish_test();

        start_test("enable toggling");
        for (i = 0; i < 3; i++) begin
            drive_cfg(1'b0, cur_step);
            k = 20 + random_below(100);
            idle_check(k, last_value);     // phase and sample held
            drive_cfg(1'b1, random_step());
            repeat (N_TOGGLE / 3) next_sample();
        end
        finish_test();

        $display("checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
